/* hw/fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// issue queue depth, equal to the credits held by the sender after reset
`define FPU_QUEUE_DEPTH 4

// major opcode of the OP-FP group
`define FPU_OPCODE_FP 7'h53

// funct5 codes, instr[31:27]
`define FPU_F5_FSGNJ   5'b00100
`define FPU_F5_FMINMAX 5'b00101
`define FPU_F5_FCMP    5'b10100
`define FPU_F5_FMV_X   5'b11100
`define FPU_F5_FMV_W   5'b11110

// floating-point CSR addresses
`define FPU_CSR_FFLAGS 12'h001
`define FPU_CSR_FRM    12'h002
`define FPU_CSR_FCSR   12'h003

`endif

/* hw/fpu_pkg.sv */
package fpu_pkg;

  // single-precision value or integer word
  typedef logic [31:0] fp_data_t;

  // register index
  typedef logic [4:0] fp_addr_t;

  // exception flags, NV DZ OF UF NX from msb down
  typedef logic [4:0] fp_flags_t;

  // rounding mode
  typedef logic [2:0] fp_rm_t;

  // csr address
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    FP_OP_NONE,
    FP_OP_SGNJ,
    FP_OP_SGNJN,
    FP_OP_SGNJX,
    FP_OP_MIN,
    FP_OP_MAX,
    FP_OP_EQ,
    FP_OP_LT,
    FP_OP_LE,
    FP_OP_CLASS,
    FP_OP_MV_X,
    FP_OP_MV_W
  } fp_op_e;

endpackage

/* hw/fpu_issue_queue.sv */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_issue_queue (
  input  logic              clock,
  input  logic              reset,
  input  logic              push_i,
  input  fpu_pkg::fp_data_t push_instr_i,
  input  fpu_pkg::fp_data_t push_int_i,
  output logic              head_valid_o,
  output fpu_pkg::fp_data_t head_instr_o,
  output fpu_pkg::fp_data_t head_int_o,
  output logic              credit_o
);
  import fpu_pkg::*;

  localparam int DEPTH = `FPU_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fp_data_t instr_mem [DEPTH];
  fp_data_t int_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop          = (count != '0);  // the pipeline never stalls
  assign head_valid_o = pop;
  assign head_instr_o = instr_mem[rd_ptr];
  assign head_int_o   = int_mem[rd_ptr];
  assign credit_o     = pop;  // slot frees at this edge

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(push_i) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push_i) begin
      instr_mem[wr_ptr] <= push_instr_i;
      int_mem[wr_ptr]   <= push_int_i;
    end
  end

endmodule

/* hw/fpu_decode.sv */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_decode (
  input  fpu_pkg::fp_data_t instr_i,
  output fpu_pkg::fp_op_e   op_o,
  output fpu_pkg::fp_addr_t rs1_o,
  output fpu_pkg::fp_addr_t rs2_o,
  output fpu_pkg::fp_addr_t rd_o,
  output logic              frden1_o,
  output logic              frden2_o,
  output logic              fwren_o,
  output logic              wren_o,
  output logic              legal_o
);
  import fpu_pkg::*;

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic [1:0] fmt;
  logic [2:0] funct3;
  fp_op_e op;
  logic frden1;
  logic frden2;
  logic fwren;
  logic wren;
  logic legal;

  assign opcode = instr_i[6:0];
  assign funct5 = instr_i[31:27];
  assign fmt    = instr_i[26:25];
  assign funct3 = instr_i[14:12];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  always_comb begin
    op     = FP_OP_NONE;
    frden1 = 1'b0;
    frden2 = 1'b0;
    fwren  = 1'b0;
    wren   = 1'b0;
    legal  = (opcode == `FPU_OPCODE_FP) && (fmt == 2'b00);  // single precision only
    case (funct5)
      `FPU_F5_FSGNJ: begin
        frden1 = 1'b1;
        frden2 = 1'b1;
        fwren  = 1'b1;
        case (funct3)
          3'd0:    op = FP_OP_SGNJ;
          3'd1:    op = FP_OP_SGNJN;
          3'd2:    op = FP_OP_SGNJX;
          default: legal = 1'b0;
        endcase
      end
      `FPU_F5_FMINMAX: begin
        frden1 = 1'b1;
        frden2 = 1'b1;
        fwren  = 1'b1;
        case (funct3)
          3'd0:    op = FP_OP_MIN;
          3'd1:    op = FP_OP_MAX;
          default: legal = 1'b0;
        endcase
      end
      `FPU_F5_FCMP: begin
        frden1 = 1'b1;
        frden2 = 1'b1;
        wren   = 1'b1;
        case (funct3)
          3'd0:    op = FP_OP_LE;
          3'd1:    op = FP_OP_LT;
          3'd2:    op = FP_OP_EQ;
          default: legal = 1'b0;
        endcase
      end
      `FPU_F5_FMV_X: begin
        frden1 = 1'b1;
        wren   = 1'b1;
        case (funct3)
          3'd0:    op = FP_OP_MV_X;
          3'd1:    op = FP_OP_CLASS;
          default: legal = 1'b0;
        endcase
      end
      `FPU_F5_FMV_W: begin
        fwren = 1'b1;  // source is the integer operand
        if (funct3 == 3'd0) begin
          op = FP_OP_MV_W;
        end else begin
          legal = 1'b0;
        end
      end
      default: legal = 1'b0;
    endcase
  end

  // an illegal word reads and writes nothing
  assign op_o     = legal ? op : FP_OP_NONE;
  assign frden1_o = legal & frden1;
  assign frden2_o = legal & frden2;
  assign fwren_o  = legal & fwren;
  assign wren_o   = legal & wren;
  assign legal_o  = legal;

endmodule

/* hw/fpu_regfile.sv */
`timescale 1ns/1ns

module fpu_regfile (
  input  logic              clock,
  input  fpu_pkg::fp_addr_t raddr1_i,
  input  fpu_pkg::fp_addr_t raddr2_i,
  output fpu_pkg::fp_data_t rdata1_o,
  output fpu_pkg::fp_data_t rdata2_o,
  input  logic              wren_i,
  input  fpu_pkg::fp_addr_t waddr_i,
  input  fpu_pkg::fp_data_t wdata_i
);
  import fpu_pkg::*;

  fp_data_t regs [32];  // f0 is an ordinary register

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

  always_ff @(posedge clock) begin
    if (wren_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

/* hw/fpu_forwarding.sv */
`timescale 1ns/1ns

module fpu_forwarding (
  input  fpu_pkg::fp_addr_t rs1_i,
  input  fpu_pkg::fp_addr_t rs2_i,
  input  logic              frden1_i,
  input  logic              frden2_i,
  input  fpu_pkg::fp_data_t rf_data1_i,
  input  fpu_pkg::fp_data_t rf_data2_i,
  input  logic              ex_fwren_i,
  input  fpu_pkg::fp_addr_t ex_rd_i,
  input  fpu_pkg::fp_data_t ex_data_i,
  input  logic              wb_fwren_i,
  input  fpu_pkg::fp_addr_t wb_rd_i,
  input  fpu_pkg::fp_data_t wb_data_i,
  output fpu_pkg::fp_data_t op1_o,
  output fpu_pkg::fp_data_t op2_o
);
  import fpu_pkg::*;

  // youngest producer wins
  function automatic fp_data_t pick(input logic rden, input fp_addr_t rs, input fp_data_t rf);
    if (!rden) begin
      return '0;
    end
    if (ex_fwren_i && (ex_rd_i == rs)) begin
      return ex_data_i;
    end
    if (wb_fwren_i && (wb_rd_i == rs)) begin
      return wb_data_i;
    end
    return rf;
  endfunction

  assign op1_o = pick(frden1_i, rs1_i, rf_data1_i);
  assign op2_o = pick(frden2_i, rs2_i, rf_data2_i);

endmodule

/* hw/fpu_execute.sv */
`timescale 1ns/1ns

module fpu_execute (
  input  fpu_pkg::fp_op_e   op_i,
  input  fpu_pkg::fp_data_t op1_i,
  input  fpu_pkg::fp_data_t op2_i,
  input  fpu_pkg::fp_data_t int_i,
  output fpu_pkg::fp_data_t result_o,
  output fpu_pkg::fp_flags_t flags_o
);
  import fpu_pkg::*;

  localparam fp_data_t CANON_NAN = 32'h7fc00000;

  logic a_nan;
  logic b_nan;
  logic any_snan;
  logic a_lt_b;
  logic a_eq_b;
  logic nv;
  fp_data_t result;

  function automatic logic is_nan(input fp_data_t x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  // total order on non-NaN values, -0 sorts below +0
  function automatic logic less(input fp_data_t a, input fp_data_t b);
    if (a[31] != b[31]) begin
      return a[31];
    end
    if (a[31]) begin
      return a[30:0] > b[30:0];
    end
    return a[30:0] < b[30:0];
  endfunction

  function automatic logic [9:0] classify(input fp_data_t x);
    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    logic [9:0] mask;
    exp_ones = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    mask = '0;
    if (exp_ones && man_zero) begin
      mask[x[31] ? 0 : 7] = 1'b1;
    end else if (exp_ones) begin
      mask[x[22] ? 9 : 8] = 1'b1;  // quiet bit picks qNaN
    end else if (exp_zero && man_zero) begin
      mask[x[31] ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      mask[x[31] ? 2 : 5] = 1'b1;
    end else begin
      mask[x[31] ? 1 : 6] = 1'b1;
    end
    return mask;
  endfunction

  assign a_nan    = is_nan(op1_i);
  assign b_nan    = is_nan(op2_i);
  assign any_snan = (a_nan & ~op1_i[22]) | (b_nan & ~op2_i[22]);
  assign a_lt_b   = less(op1_i, op2_i);
  assign a_eq_b   = (op1_i == op2_i);

  always_comb begin
    result = '0;
    nv     = 1'b0;
    case (op_i)
      FP_OP_SGNJ:  result = {op2_i[31], op1_i[30:0]};
      FP_OP_SGNJN: result = {~op2_i[31], op1_i[30:0]};
      FP_OP_SGNJX: result = {op1_i[31] ^ op2_i[31], op1_i[30:0]};
      FP_OP_MIN, FP_OP_MAX: begin
        nv = any_snan;
        if (a_nan && b_nan) begin
          result = CANON_NAN;
        end else if (a_nan) begin
          result = op2_i;
        end else if (b_nan) begin
          result = op1_i;
        end else if ((op_i == FP_OP_MIN) == a_lt_b) begin
          result = op1_i;
        end else begin
          result = op2_i;
        end
      end
      FP_OP_EQ: begin
        nv     = any_snan;
        result = {31'b0, ~a_nan & ~b_nan & a_eq_b};
      end
      FP_OP_LT: begin
        nv     = a_nan | b_nan;  // signaling compare
        result = {31'b0, ~a_nan & ~b_nan & a_lt_b};
      end
      FP_OP_LE: begin
        nv     = a_nan | b_nan;
        result = {31'b0, ~a_nan & ~b_nan & (a_lt_b | a_eq_b)};
      end
      FP_OP_CLASS: result = {22'b0, classify(op1_i)};
      FP_OP_MV_X:  result = op1_i;
      FP_OP_MV_W:  result = int_i;
      default:     result = '0;
    endcase
  end

  assign result_o = result;
  assign flags_o  = {nv, 4'b0};  // only NV can be raised here

endmodule

/* hw/fpu_csr.sv */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_csr (
  input  logic                clock,
  input  logic                reset,
  input  logic                csr_wr_i,
  input  fpu_pkg::csr_addr_t  csr_addr_i,
  input  fpu_pkg::fp_data_t   csr_wdata_i,
  output fpu_pkg::fp_data_t   csr_rdata_o,
  input  logic                accrue_i,
  input  fpu_pkg::fp_flags_t  accrue_flags_i,
  output fpu_pkg::fp_rm_t     frm_o
);
  import fpu_pkg::*;

  fp_flags_t fflags;
  fp_rm_t frm;
  fp_flags_t fflags_next;
  fp_rm_t frm_next;

  always_comb begin
    case (csr_addr_i)
      `FPU_CSR_FFLAGS: csr_rdata_o = {27'b0, fflags};
      `FPU_CSR_FRM:    csr_rdata_o = {29'b0, frm};
      `FPU_CSR_FCSR:   csr_rdata_o = {24'b0, frm, fflags};
      default:         csr_rdata_o = '0;
    endcase
  end

  always_comb begin
    fflags_next = fflags;
    frm_next    = frm;
    if (csr_wr_i) begin
      case (csr_addr_i)
        `FPU_CSR_FFLAGS: fflags_next = csr_wdata_i[4:0];
        `FPU_CSR_FRM:    frm_next = csr_wdata_i[2:0];
        `FPU_CSR_FCSR: begin
          fflags_next = csr_wdata_i[4:0];
          frm_next    = csr_wdata_i[7:5];
        end
        default: ;
      endcase
    end
    // flags from writeback land on top of a same-cycle write
    if (accrue_i) begin
      fflags_next = fflags_next | accrue_flags_i;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fflags <= '0;
      frm    <= '0;
    end else begin
      fflags <= fflags_next;
      frm    <= frm_next;
    end
  end

  assign frm_o = frm;

endmodule

/* hw/fpu_core.sv */
`timescale 1ns/1ns

module fpu_core (
  input  logic               clock,
  input  logic               reset,
  input  logic               instr_valid_i,
  input  fpu_pkg::fp_data_t  instr_i,
  input  fpu_pkg::fp_data_t  int_data_i,
  output logic               credit_o,
  output logic               int_wr_valid_o,
  output fpu_pkg::fp_addr_t  int_wr_rd_o,
  output fpu_pkg::fp_data_t  int_wr_data_o,
  output logic               illegal_o,
  input  logic               csr_wr_i,
  input  fpu_pkg::csr_addr_t csr_addr_i,
  input  fpu_pkg::fp_data_t  csr_wdata_i,
  output fpu_pkg::fp_data_t  csr_rdata_o
);
  import fpu_pkg::*;

  logic head_valid;
  fp_data_t head_instr;
  fp_data_t head_int;
  fp_op_e dec_op;
  fp_addr_t dec_rs1;
  fp_addr_t dec_rs2;
  fp_addr_t dec_rd;
  logic dec_frden1;
  logic dec_frden2;
  logic dec_fwren;
  logic dec_wren;
  logic dec_legal;
  fp_data_t rf_data1;
  fp_data_t rf_data2;
  fp_data_t fwd_op1;
  fp_data_t fwd_op2;

  // execute stage
  logic ex_fwren;
  logic ex_wren;
  logic ex_legal;
  logic ex_illegal;
  fp_op_e ex_op;
  fp_data_t ex_op1;
  fp_data_t ex_op2;
  fp_data_t ex_int;
  fp_addr_t ex_rd;
  fp_data_t ex_result;
  fp_flags_t ex_flags;

  // writeback stage
  logic wb_fwren;
  logic wb_wren;
  logic wb_accrue;
  logic wb_illegal;
  fp_addr_t wb_rd;
  fp_data_t wb_data;
  fp_flags_t wb_flags;

  fpu_issue_queue i_queue (
    .clock        (clock),
    .reset        (reset),
    .push_i       (instr_valid_i),
    .push_instr_i (instr_i),
    .push_int_i   (int_data_i),
    .head_valid_o (head_valid),
    .head_instr_o (head_instr),
    .head_int_o   (head_int),
    .credit_o     (credit_o)
  );

  fpu_decode i_decode (
    .instr_i  (head_instr),
    .op_o     (dec_op),
    .rs1_o    (dec_rs1),
    .rs2_o    (dec_rs2),
    .rd_o     (dec_rd),
    .frden1_o (dec_frden1),
    .frden2_o (dec_frden2),
    .fwren_o  (dec_fwren),
    .wren_o   (dec_wren),
    .legal_o  (dec_legal)
  );

  fpu_regfile i_regfile (
    .clock    (clock),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (rf_data1),
    .rdata2_o (rf_data2),
    .wren_i   (wb_fwren),
    .waddr_i  (wb_rd),
    .wdata_i  (wb_data)
  );

  fpu_forwarding i_forwarding (
    .rs1_i      (dec_rs1),
    .rs2_i      (dec_rs2),
    .frden1_i   (dec_frden1),
    .frden2_i   (dec_frden2),
    .rf_data1_i (rf_data1),
    .rf_data2_i (rf_data2),
    .ex_fwren_i (ex_fwren),
    .ex_rd_i    (ex_rd),
    .ex_data_i  (ex_result),
    .wb_fwren_i (wb_fwren),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .op1_o      (fwd_op1),
    .op2_o      (fwd_op2)
  );

  fpu_execute i_execute (
    .op_i     (ex_op),
    .op1_i    (ex_op1),
    .op2_i    (ex_op2),
    .int_i    (ex_int),
    .result_o (ex_result),
    .flags_o  (ex_flags)
  );

  fpu_csr i_csr (
    .clock          (clock),
    .reset          (reset),
    .csr_wr_i       (csr_wr_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o),
    .accrue_i       (wb_accrue),
    .accrue_flags_i (wb_flags),
    .frm_o          ()  // no rounding op here yet
  );

  always_ff @(posedge clock) begin
    if (!reset) begin
      ex_fwren       <= 1'b0;
      ex_wren        <= 1'b0;
      ex_legal       <= 1'b0;
      ex_illegal     <= 1'b0;
      wb_fwren       <= 1'b0;
      wb_wren        <= 1'b0;
      wb_accrue      <= 1'b0;
      wb_illegal     <= 1'b0;
      int_wr_valid_o <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      ex_fwren       <= head_valid & dec_fwren;  // head pops every valid cycle
      ex_wren        <= head_valid & dec_wren;
      ex_legal       <= head_valid & dec_legal;
      ex_illegal     <= head_valid & ~dec_legal;
      wb_fwren       <= ex_fwren;
      wb_wren        <= ex_wren;
      wb_accrue      <= ex_legal;
      wb_illegal     <= ex_illegal;
      int_wr_valid_o <= wb_wren;
      illegal_o      <= wb_illegal;
    end
  end

  always_ff @(posedge clock) begin
    ex_op         <= dec_op;
    ex_op1        <= fwd_op1;
    ex_op2        <= fwd_op2;
    ex_int        <= head_int;
    ex_rd         <= dec_rd;
    wb_rd         <= ex_rd;
    wb_data       <= ex_result;
    wb_flags      <= ex_flags;
    int_wr_rd_o   <= wb_rd;
    int_wr_data_o <= wb_data;
  end

endmodule

/* bench/fpu_core_tb.sv */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_core_tb;
  import fpu_pkg::*;

  logic clock;
  logic reset;
  logic instr_valid_i;
  fp_data_t instr_i;
  fp_data_t int_data_i;
  logic credit_o;
  logic int_wr_valid_o;
  fp_addr_t int_wr_rd_o;
  fp_data_t int_wr_data_o;
  logic illegal_o;
  logic csr_wr_i;
  csr_addr_t csr_addr_i;
  fp_data_t csr_wdata_i;
  fp_data_t csr_rdata_o;

  int error_count = 0;
  int check_count = 0;
  int credits = `FPU_QUEUE_DEPTH;
  int credit_pulses = 0;
  int issued_count = 0;
  int cycle_count = 0;
  logic issued_any = 1'b0;
  logic [31:0] lfsr_state = 32'hb77;

  // reference model state
  fp_data_t model_fregs [32];
  fp_flags_t model_fflags = '0;
  fp_rm_t model_frm = '0;
  logic exp_illegal [$];
  fp_addr_t exp_rd [$];
  fp_data_t exp_data [$];

  // f1..f16 hold these after the table is loaded
  fp_data_t special_vals [16] = '{
    32'h00000000, 32'h80000000, 32'h3f800000, 32'hbf800000,
    32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001,
    32'hffc00005, 32'hff812345, 32'h00000001, 32'h807fffff,
    32'h40490fdb, 32'hc0490fdb, 32'h3f800001, 32'h00800000
  };
  fp_op_e fp_ops [5] = '{FP_OP_SGNJ, FP_OP_SGNJN, FP_OP_SGNJX, FP_OP_MIN, FP_OP_MAX};
  fp_op_e cmp_ops [3] = '{FP_OP_EQ, FP_OP_LT, FP_OP_LE};

  fpu_core i_dut (
    .clock          (clock),
    .reset          (reset),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .int_data_i     (int_data_i),
    .credit_o       (credit_o),
    .int_wr_valid_o (int_wr_valid_o),
    .int_wr_rd_o    (int_wr_rd_o),
    .int_wr_data_o  (int_wr_data_o),
    .illegal_o      (illegal_o),
    .csr_wr_i       (csr_wr_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic nan_value(input fp_data_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic signaling_nan(input fp_data_t x);
    return nan_value(x) && !x[22];
  endfunction

  // maps a non-NaN value to an unsigned key in the same order, -0 below +0
  function automatic logic [31:0] order_key(input fp_data_t x);
    return x[31] ? ~x : (x | 32'h80000000);
  endfunction

  function automatic fp_data_t class_mask(input fp_data_t x);
    int idx;
    if (x[30:23] == 8'hff) begin
      if (x[22:0] == 23'd0) begin
        idx = x[31] ? 0 : 7;
      end else begin
        idx = x[22] ? 9 : 8;
      end
    end else if (x[30:23] == 8'h00) begin
      if (x[22:0] == 23'd0) begin
        idx = x[31] ? 3 : 4;
      end else begin
        idx = x[31] ? 2 : 5;
      end
    end else begin
      idx = x[31] ? 1 : 6;
    end
    return 32'd1 << idx;
  endfunction

  function automatic fp_data_t model_result(input fp_op_e op, input fp_data_t a,
                                            input fp_data_t b, input fp_data_t iv);
    logic either_nan;
    either_nan = nan_value(a) || nan_value(b);
    case (op)
      FP_OP_SGNJ:  return {b[31], a[30:0]};
      FP_OP_SGNJN: return {!b[31], a[30:0]};
      FP_OP_SGNJX: return {a[31] ^ b[31], a[30:0]};
      FP_OP_MIN, FP_OP_MAX: begin
        if (nan_value(a) && nan_value(b)) begin
          return 32'h7fc00000;  // canonical NaN
        end
        if (nan_value(a)) begin
          return b;
        end
        if (nan_value(b)) begin
          return a;
        end
        if (op == FP_OP_MIN) begin
          return (order_key(a) < order_key(b)) ? a : b;
        end
        return (order_key(a) > order_key(b)) ? a : b;
      end
      FP_OP_EQ:    return {31'b0, !either_nan && (order_key(a) == order_key(b))};
      FP_OP_LT:    return {31'b0, !either_nan && (order_key(a) < order_key(b))};
      FP_OP_LE:    return {31'b0, !either_nan && (order_key(a) <= order_key(b))};
      FP_OP_CLASS: return class_mask(a);
      FP_OP_MV_X:  return a;
      FP_OP_MV_W:  return iv;
      default:     return '0;
    endcase
  endfunction

  function automatic logic model_nv(input fp_op_e op, input fp_data_t a, input fp_data_t b);
    case (op)
      FP_OP_MIN, FP_OP_MAX, FP_OP_EQ: return signaling_nan(a) || signaling_nan(b);
      FP_OP_LT, FP_OP_LE:             return nan_value(a) || nan_value(b);
      default:                        return 1'b0;
    endcase
  endfunction

  // funct5 and funct3 of each operation
  function automatic logic [7:0] op_fields(input fp_op_e op);
    case (op)
      FP_OP_SGNJ:  return {`FPU_F5_FSGNJ, 3'd0};
      FP_OP_SGNJN: return {`FPU_F5_FSGNJ, 3'd1};
      FP_OP_SGNJX: return {`FPU_F5_FSGNJ, 3'd2};
      FP_OP_MIN:   return {`FPU_F5_FMINMAX, 3'd0};
      FP_OP_MAX:   return {`FPU_F5_FMINMAX, 3'd1};
      FP_OP_EQ:    return {`FPU_F5_FCMP, 3'd2};
      FP_OP_LT:    return {`FPU_F5_FCMP, 3'd1};
      FP_OP_LE:    return {`FPU_F5_FCMP, 3'd0};
      FP_OP_CLASS: return {`FPU_F5_FMV_X, 3'd1};
      FP_OP_MV_X:  return {`FPU_F5_FMV_X, 3'd0};
      default:     return {`FPU_F5_FMV_W, 3'd0};
    endcase
  endfunction

  function automatic fp_data_t encode(input logic [4:0] f5, input logic [2:0] f3,
                                      input fp_addr_t rs2, input fp_addr_t rs1,
                                      input fp_addr_t rd);
    return {f5, 2'b00, rs2, rs1, f3, rd, `FPU_OPCODE_FP};
  endfunction

  task automatic step;
    @(posedge clock);
    #10;
  endtask

  task automatic compare_value(input string name, input fp_data_t got, input fp_data_t expected);
    check_count++;
    assert (got === expected) else begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic send_word(input fp_data_t word, input fp_data_t int_val);
    while (credits == 0) begin
      step;
    end
    instr_valid_i = 1'b1;
    instr_i = word;
    int_data_i = int_val;
    credits--;
    issued_count++;
    issued_any = 1'b1;
    check_count++;
    assert (credits >= 0) else begin
      error_count++;
      $display("credit count dropped below zero");
    end
    step;
    instr_valid_i = 1'b0;
  endtask

  task automatic issue_op(input fp_op_e op, input fp_addr_t rd, input fp_addr_t rs1,
                          input fp_addr_t rs2, input fp_data_t int_val);
    fp_data_t res;
    logic [7:0] fields;
    res = model_result(op, model_fregs[rs1], model_fregs[rs2], int_val);
    if (model_nv(op, model_fregs[rs1], model_fregs[rs2])) begin
      model_fflags[4] = 1'b1;
    end
    fields = op_fields(op);
    if (fields[7:3] == `FPU_F5_FSGNJ || fields[7:3] == `FPU_F5_FMINMAX ||
        fields[7:3] == `FPU_F5_FMV_W) begin
      model_fregs[rd] = res;
    end else begin
      exp_illegal.push_back(1'b0);
      exp_rd.push_back(rd);
      exp_data.push_back(res);
    end
    send_word(encode(fields[7:3], fields[2:0], rs2, rs1, rd), int_val);
  endtask

  task automatic issue_illegal(input fp_data_t word);
    exp_illegal.push_back(1'b1);
    exp_rd.push_back(5'd0);
    exp_data.push_back(32'd0);
    send_word(word, 32'd0);
  endtask

  // result through f20, then read back to the integer port
  task automatic pair_readback(input fp_op_e op, input int a, input int b);
    issue_op(op, 5'd20, 5'(a + 1), 5'(b + 1), 32'd0);
    issue_op(FP_OP_MV_X, 5'(rand_bits(5)), 5'd20, 5'd0, 32'd0);
  endtask

  task automatic pair_compare(input fp_op_e op, input int a, input int b);
    issue_op(op, 5'(rand_bits(5)), 5'(a + 1), 5'(b + 1), 32'd0);
  endtask

  task automatic drain;
    while (credits != `FPU_QUEUE_DEPTH || exp_data.size() != 0) begin
      step;
    end
  endtask

  task automatic csr_write(input csr_addr_t addr, input fp_data_t data);
    csr_wr_i = 1'b1;
    csr_addr_i = addr;
    csr_wdata_i = data;
    case (addr)
      `FPU_CSR_FFLAGS: model_fflags = data[4:0];
      `FPU_CSR_FRM:    model_frm = data[2:0];
      `FPU_CSR_FCSR: begin
        model_fflags = data[4:0];
        model_frm = data[7:5];
      end
      default: ;
    endcase
    step;
    csr_wr_i = 1'b0;
  endtask

  task automatic csr_read_check(input csr_addr_t addr, input fp_data_t expected);
    csr_addr_i = addr;
    @(negedge clock);
    compare_value("csr_rdata_o", csr_rdata_o, expected);
    step;
  endtask

  task automatic csr_check_all;
    csr_read_check(`FPU_CSR_FFLAGS, {27'b0, model_fflags});
    csr_read_check(`FPU_CSR_FRM, {29'b0, model_frm});
    csr_read_check(`FPU_CSR_FCSR, {24'b0, model_frm, model_fflags});
  endtask

  always @(negedge clock) begin : monitor
    logic e_ill;
    fp_addr_t e_rd;
    fp_data_t e_data;
    if (reset) begin
      if (credit_o === 1'b1) begin
        credits++;
        credit_pulses++;
      end
      assert (credits <= `FPU_QUEUE_DEPTH) else begin
        error_count++;
        $display("credit count rose above the queue depth");
      end
      if (int_wr_valid_o === 1'b1 || illegal_o === 1'b1) begin
        if (exp_data.size() == 0) begin
          error_count++;
          $display("a result appeared with no instruction outstanding");
        end else begin
          e_ill = exp_illegal.pop_front();
          e_rd = exp_rd.pop_front();
          e_data = exp_data.pop_front();
          compare_value("illegal_o", {31'b0, illegal_o}, {31'b0, e_ill});
          if (!e_ill) begin
            compare_value("int_wr_rd_o", {27'b0, int_wr_rd_o}, {27'b0, e_rd});
            compare_value("int_wr_data_o", int_wr_data_o, e_data);
          end
        end
      end
    end
  end

  a_one_result: assert property (@(posedge clock) disable iff (!reset)
                                 !(int_wr_valid_o && illegal_o))
    else begin
      error_count++;
      $display("int_wr_valid_o and illegal_o were high in the same cycle");
    end

  a_quiet_credit: assert property (@(posedge clock) disable iff (!reset)
                                   !issued_any |-> !credit_o)
    else begin
      error_count++;
      $display("credit_o pulsed before any instruction was issued");
    end

  initial begin : watchdog
    while (cycle_count < 20 * issued_count + 200) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d instructions issued", cycle_count, issued_count);
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    fp_addr_t r;
    fp_data_t v;
    int a_idx;
    int b_idx;
    int pulses_before;
    reset = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    int_data_i = '0;
    csr_wr_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    repeat (4) @(posedge clock);
    #10;
    reset = 1'b1;
    repeat (3) step;  // credit_o must stay quiet here
    csr_check_all;

    // move round trip, through ex, wb and the register file
    for (int gap = 0; gap < 3; gap++) begin
      for (int rep = 0; rep < 4; rep++) begin
        r = 5'(rand_bits(5));
        v = rand_bits(32);
        issue_op(FP_OP_MV_W, r, 5'd0, 5'd0, v);
        for (int k = 0; k < gap; k++) begin
          issue_op(FP_OP_MV_W, r + 5'd1 + 5'(k), 5'd0, 5'd0, rand_bits(32));
        end
        issue_op(FP_OP_MV_X, 5'(rand_bits(5)), r, 5'd0, 32'd0);
      end
    end
    drain;

    // sign injection and min/max
    foreach (special_vals[i]) begin
      issue_op(FP_OP_MV_W, 5'(i + 1), 5'd0, 5'd0, special_vals[i]);
    end
    pair_readback(FP_OP_MIN, 6, 7);
    pair_readback(FP_OP_MAX, 7, 2);
    pair_readback(FP_OP_MIN, 6, 2);
    pair_readback(FP_OP_MIN, 0, 1);
    pair_readback(FP_OP_MAX, 1, 0);
    pair_readback(FP_OP_MAX, 8, 9);
    pair_readback(FP_OP_SGNJN, 6, 1);
    pair_readback(FP_OP_SGNJX, 9, 13);
    for (int k = 0; k < 12; k++) begin
      a_idx = int'(rand_bits(4));
      b_idx = int'(rand_bits(4));
      foreach (fp_ops[i]) begin
        pair_readback(fp_ops[i], a_idx, b_idx);
      end
    end
    drain;

    // compare and classify
    foreach (special_vals[i]) begin
      issue_op(FP_OP_CLASS, 5'(i), 5'(i + 1), 5'd0, 32'd0);
    end
    pair_compare(FP_OP_EQ, 0, 1);
    pair_compare(FP_OP_LE, 1, 0);
    pair_compare(FP_OP_LT, 1, 0);
    pair_compare(FP_OP_EQ, 6, 6);
    for (int k = 0; k < 12; k++) begin
      a_idx = int'(rand_bits(4));
      b_idx = int'(rand_bits(4));
      foreach (cmp_ops[i]) begin
        pair_compare(cmp_ops[i], a_idx, b_idx);
      end
    end
    drain;

    // flags and csr access
    csr_check_all;
    csr_write(`FPU_CSR_FFLAGS, 32'd0);
    pair_compare(FP_OP_EQ, 6, 2);  // quiet compare, no NV
    drain;
    csr_check_all;
    pair_compare(FP_OP_LT, 6, 2);
    drain;
    csr_check_all;
    csr_write(`FPU_CSR_FFLAGS, 32'd0);
    pair_readback(FP_OP_MAX, 7, 2);
    drain;
    csr_check_all;
    csr_write(`FPU_CSR_FCSR, rand_bits(32));
    csr_check_all;
    csr_write(`FPU_CSR_FRM, rand_bits(32));
    csr_check_all;
    csr_read_check(12'h7c0, 32'd0);
    csr_read_check(12'h004, 32'd0);

    // illegal words must not write f1..f4
    issue_illegal(encode(5'b00000, 3'd0, 5'd2, 5'd3, 5'd1));
    issue_illegal({12'h010, 5'd2, 3'b010, 5'd2, 7'h07});  // flw
    issue_illegal(encode(`FPU_F5_FSGNJ, 3'd3, 5'd2, 5'd3, 5'd3));
    issue_illegal(encode(`FPU_F5_FSGNJ, 3'd0, 5'd2, 5'd3, 5'd4) | 32'h02000000);
    for (int k = 1; k <= 4; k++) begin
      issue_op(FP_OP_MV_X, 5'(k), 5'(k), 5'd0, 32'd0);
    end
    drain;

    // burst with all credits in hand
    pulses_before = credit_pulses;
    for (int k = 0; k < `FPU_QUEUE_DEPTH; k++) begin
      if (k % 2 == 0) begin
        issue_op(FP_OP_MV_W, 5'(24 + k), 5'd0, 5'd0, rand_bits(32));
      end else begin
        issue_op(FP_OP_MV_X, 5'(k), 5'(23 + k), 5'd0, 32'd0);
      end
    end
    while (exp_data.size() != 0) begin
      step;
    end
    compare_value("credit_o pulses", credit_pulses - pulses_before, `FPU_QUEUE_DEPTH);
    compare_value("credit_o total pulses", credit_pulses, issued_count);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_issue_queue.sv
hw/fpu_decode.sv
hw/fpu_regfile.sv
hw/fpu_forwarding.sv
hw/fpu_execute.sv
hw/fpu_csr.sv
hw/fpu_core.sv
bench/fpu_core_tb.sv
